//--- source/lsu_pkg.sv
// Load/store unit shared types
package lsu_pkg;

   // ====================
   // Basic words
   // ====================
   typedef logic [31:0] word_t;
   typedef logic [4:0]  reg_idx_t;

   // funct3 width codes of LB/LH/LW/LBU/LHU and SB/SH/SW
   typedef enum logic [2:0] {
      acc_byte   = 3'b000,
      acc_half   = 3'b001,
      acc_word   = 3'b010,
      acc_byte_u = 3'b100,
      acc_half_u = 3'b101
   } access_t;

   // AHB-Lite HSIZE, only the first three codes are used here
   typedef logic [2:0] hsize_t;

   localparam logic [6:0] opcode_load  = 7'b0000011;
   localparam logic [6:0] opcode_store = 7'b0100011;

   // ====================
   // Instruction views
   // ====================
   typedef struct packed {
      logic [11:0] imm12;
      reg_idx_t    rs1;
      logic [2:0]  funct3;
      reg_idx_t    rd;
      logic [6:0]  opcode;
   } load_fmt_t;

   typedef struct packed {
      logic [6:0]  imm_hi;
      reg_idx_t    rs2;
      reg_idx_t    rs1;
      logic [2:0]  funct3;
      logic [4:0]  imm_lo;
      logic [6:0]  opcode;
   } store_fmt_t;

   // Same 32 bits read as I-type or S-type
   typedef union packed {
      load_fmt_t  load_fmt;
      store_fmt_t store_fmt;
   } inst_u;

   // Accepted memory operation
   typedef struct packed {
      logic     is_load;
      logic     is_store;
      access_t  width;
      reg_idx_t rd;
      word_t    addr;
      word_t    store_val;
   } lsu_op_t;

endpackage

//--- source/lsu_decode.sv
// Load/store instruction decode
module lsu_decode (
   input  logic              clk,
   input  logic              rst_n,
   input  lsu_pkg::inst_u    instr,
   input  logic              instr_valid,
   input  lsu_pkg::word_t    rs1_data,
   input  lsu_pkg::word_t    rs2_data,
   input  logic              hready,
   output lsu_pkg::lsu_op_t  op,
   output logic              illegal_instruction
);
   import lsu_pkg::*;

   logic     accept;
   logic     is_ld;
   logic     is_st;
   word_t    imm_ld;
   word_t    imm_st;
   logic     load_q;
   logic     store_q;
   logic     illegal_q;
   access_t  width_q;
   reg_idx_t rd_q;
   word_t    addr_q;
   word_t    store_val_q;

   assign accept = instr_valid & hready;

   // Opcode sits at the same place in both views
   assign is_ld = (instr.load_fmt.opcode == opcode_load);
   assign is_st = (instr.store_fmt.opcode == opcode_store);

   // ====================
   // Immediate rebuild
   // ====================
   assign imm_ld = {{20{instr.load_fmt.imm12[11]}}, instr.load_fmt.imm12};
   assign imm_st = {{20{instr.store_fmt.imm_hi[6]}}, instr.store_fmt.imm_hi,
                    instr.store_fmt.imm_lo};

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         load_q    <= 1'b0;
         store_q   <= 1'b0;
         illegal_q <= 1'b0;
      end else begin
         // Pulse lasts a single cycle whatever hready does next
         illegal_q <= accept & ~is_ld & ~is_st;
         if (hready) begin
            load_q  <= accept & is_ld;
            store_q <= accept & is_st;
         end
      end
   end

   always_ff @(posedge clk) begin
      if (accept) begin
         width_q     <= access_t'(instr.load_fmt.funct3);
         rd_q        <= instr.load_fmt.rd;
         addr_q      <= rs1_data + (is_st ? imm_st : imm_ld);
         store_val_q <= rs2_data;
      end
   end

   assign op.is_load   = load_q;
   assign op.is_store  = store_q;
   assign op.width     = width_q;
   assign op.rd        = rd_q;
   assign op.addr      = addr_q;
   assign op.store_val = store_val_q;

   assign illegal_instruction = illegal_q;

   // An illegal word must never start a transfer
   a_illegal_no_xfer : assert property (@(posedge clk) disable iff (!rst_n)
      $rose(illegal_instruction) |-> !(op.is_load || op.is_store));

endmodule

//--- source/lsu_addr_phase.sv
// AHB-Lite address phase
module lsu_addr_phase (
   input  lsu_pkg::lsu_op_t  op,
   output lsu_pkg::word_t    haddr,
   output lsu_pkg::hsize_t   hsize,
   output logic              htrans,
   output logic              hwrite,
   output lsu_pkg::word_t    wdata_lanes,
   output lsu_pkg::access_t  width,
   output lsu_pkg::reg_idx_t rd_idx,
   output logic [1:0]        byte_off
);
   import lsu_pkg::*;

   localparam hsize_t hsize_byte = 3'd0;
   localparam hsize_t hsize_half = 3'd1;
   localparam hsize_t hsize_word = 3'd2;

   word_t byte_val;

   // ====================
   // Bus control
   // ====================
   assign htrans = op.is_load | op.is_store;
   assign hwrite = op.is_store;

   // Full address goes out, misalignment is not trapped
   assign haddr = op.addr;

   always_comb begin
      case (op.width)
         acc_byte, acc_byte_u: hsize = hsize_byte;
         acc_half, acc_half_u: hsize = hsize_half;
         // Unused funct3 codes fall back to a word
         default:              hsize = hsize_word;
      endcase
   end

   // ====================
   // Store lane steering
   // ====================
   assign byte_val = word_t'(op.store_val[7:0]);

   always_comb begin
      case (op.width)
         acc_byte, acc_byte_u: begin
            wdata_lanes = byte_val << {op.addr[1:0], 3'b000};
         end
         acc_half, acc_half_u: begin
            // Halfword position comes from bit 1 only
            if (op.addr[1]) begin
               wdata_lanes = {op.store_val[15:0], 16'h0000};
            end else begin
               wdata_lanes = {16'h0000, op.store_val[15:0]};
            end
         end
         default: begin
            wdata_lanes = op.store_val;
         end
      endcase
   end

   // State carried over to the data phase
   assign width    = op.width;
   assign rd_idx   = op.rd;
   assign byte_off = op.addr[1:0];

   // Size stays within the 32-bit bus
   always_comb begin
      if (htrans) begin
         a_hsize_range : assert (hsize <= hsize_word)
            else $error("hsize %0d exceeds word", hsize);
      end
   end

endmodule

//--- source/lsu_data_phase.sv
// AHB-Lite data phase and load extraction
module lsu_data_phase (
   input  logic              clk,
   input  logic              rst_n,
   input  logic              hready,
   input  logic              htrans,
   input  logic              hwrite,
   input  lsu_pkg::word_t    wdata_lanes,
   input  lsu_pkg::access_t  width,
   input  lsu_pkg::reg_idx_t rd_idx,
   input  logic [1:0]        byte_off,
   input  lsu_pkg::word_t    hrdata,
   output lsu_pkg::word_t    hwdata,
   output logic              load_valid,
   output lsu_pkg::reg_idx_t load_rd,
   output lsu_pkg::word_t    load_data
);
   import lsu_pkg::*;

   logic       load_pend;
   access_t    width_q;
   reg_idx_t   rd_q;
   logic [1:0] off_q;
   word_t      wdata_q;
   logic [7:0] byte_sel;
   logic [15:0] half_sel;

   // ====================
   // Data-phase state
   // ====================
   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         load_pend <= 1'b0;
      end else if (hready) begin
         load_pend <= htrans & ~hwrite;
      end
   end

   // Held for the whole data phase while hready is low
   always_ff @(posedge clk) begin
      if (hready) begin
         width_q <= width;
         rd_q    <= rd_idx;
         off_q   <= byte_off;
         wdata_q <= wdata_lanes;
      end
   end

   assign hwdata = wdata_q;

   // Load completes on the edge that ends the data phase
   assign load_valid = load_pend & hready;
   assign load_rd    = rd_q;

   // ====================
   // Load extraction
   // ====================
   assign byte_sel = hrdata[{off_q, 3'b000} +: 8];
   assign half_sel = off_q[1] ? hrdata[31:16] : hrdata[15:0];

   always_comb begin
      case (width_q)
         acc_byte: begin
            load_data = {{24{byte_sel[7]}}, byte_sel};
         end
         acc_byte_u: begin
            load_data = {24'h000000, byte_sel};
         end
         acc_half: begin
            load_data = {{16{half_sel[15]}}, half_sel};
         end
         acc_half_u: begin
            load_data = {16'h0000, half_sel};
         end
         default: begin
            load_data = hrdata;
         end
      endcase
   end

   // No result may be reported inside a wait state
   a_no_load_in_wait : assert property (@(posedge clk) disable iff (!rst_n)
      !hready |-> !load_valid);

endmodule

//--- source/lsu_top.sv
// Load/store unit top level
module lsu_top (
   input  logic              clk,
   input  logic              rst_n,
   input  lsu_pkg::inst_u    instr,
   input  logic              instr_valid,
   input  lsu_pkg::word_t    rs1_data,
   input  lsu_pkg::word_t    rs2_data,
   input  lsu_pkg::word_t    hrdata,
   input  logic              hready,
   output lsu_pkg::word_t    haddr,
   output lsu_pkg::hsize_t   hsize,
   output logic              htrans,
   output logic              hwrite,
   output lsu_pkg::word_t    hwdata,
   output logic              load_valid,
   output lsu_pkg::reg_idx_t load_rd,
   output lsu_pkg::word_t    load_data,
   output logic              illegal_instruction
);
   import lsu_pkg::*;

   lsu_op_t    op;
   word_t      wdata_lanes;
   access_t    width;
   reg_idx_t   rd_idx;
   logic [1:0] byte_off;

   // ====================
   // Decode stage
   // ====================
   lsu_decode u_decode (
      .clk                 (clk),
      .rst_n               (rst_n),
      .instr               (instr),
      .instr_valid         (instr_valid),
      .rs1_data            (rs1_data),
      .rs2_data            (rs2_data),
      .hready              (hready),
      .op                  (op),
      .illegal_instruction (illegal_instruction)
   );

   // Address phase is combinational from the decoded op
   lsu_addr_phase u_addr_phase (
      .op          (op),
      .haddr       (haddr),
      .hsize       (hsize),
      .htrans      (htrans),
      .hwrite      (hwrite),
      .wdata_lanes (wdata_lanes),
      .width       (width),
      .rd_idx      (rd_idx),
      .byte_off    (byte_off)
   );

   lsu_data_phase u_data_phase (
      .clk         (clk),
      .rst_n       (rst_n),
      .hready      (hready),
      .htrans      (htrans),
      .hwrite      (hwrite),
      .wdata_lanes (wdata_lanes),
      .width       (width),
      .rd_idx      (rd_idx),
      .byte_off    (byte_off),
      .hrdata      (hrdata),
      .hwdata      (hwdata),
      .load_valid  (load_valid),
      .load_rd     (load_rd),
      .load_data   (load_data)
   );

endmodule

//--- tests/lsu_ref.svh
// Load/store reference model
`ifndef LSU_REF_SVH
`define LSU_REF_SVH

// Galois LFSR with taps for x^32 + x^22 + x^2 + x + 1
function automatic logic [31:0] lfsr_step(input logic [31:0] s);
   logic lsb;
   lsb = s[0];
   s = s >> 1;
   if (lsb) begin
      s = s ^ 32'h80200003;
   end
   return s;
endfunction

function automatic word_t expected_addr(input word_t rs1, input logic [11:0] imm);
   return rs1 + {{20{imm[11]}}, imm};
endfunction

function automatic hsize_t expected_size(input access_t w);
   if (w == acc_byte || w == acc_byte_u) return 3'd0;
   if (w == acc_half || w == acc_half_u) return 3'd1;
   return 3'd2;
endfunction

function automatic word_t steer_store(input word_t val, input access_t w, input logic [1:0] off);
   word_t r;
   r = '0;
   if (w == acc_byte) begin
      for (int k = 0; k < 4; k++) begin
         if (k == int'(off)) r[8*k +: 8] = val[7:0];
      end
   end else if (w == acc_half) begin
      r = off[1] ? {val[15:0], 16'h0000} : {16'h0000, val[15:0]};
   end else begin
      r = val;
   end
   return r;
endfunction

function automatic word_t extract_load(input word_t m, input access_t w, input logic [1:0] off);
   word_t sh;
   logic [15:0] h;
   sh = m >> (8 * off);
   h = off[1] ? m[31:16] : m[15:0];
   case (w)
      acc_byte:   return {{24{sh[7]}}, sh[7:0]};
      acc_byte_u: return {24'h000000, sh[7:0]};
      acc_half:   return {{16{h[15]}}, h};
      acc_half_u: return {16'h0000, h};
      default:    return m;
   endcase
endfunction

// Memory word scrambled from the full address
function automatic word_t mem_scramble(input word_t a);
   return (a * 32'h9e3779b1) ^ {a[7:0], a[31:8]};
endfunction

`endif

//--- tests/lsu_tb.sv
// Load/store unit testbench
module lsu_tb;
   timeunit 1ns;
   timeprecision 1ps;
   import lsu_pkg::*;

   localparam int num_ops = 400;

   typedef struct {
      logic    is_load;
      access_t width;
      reg_idx_t rd;
      word_t   addr;
      word_t   wdata;
      hsize_t  size;
      string   name;
   } exp_t;

   logic clk, rst_n, instr_valid, hready;
   inst_u instr;
   word_t rs1_data, rs2_data, hrdata;
   word_t haddr, hwdata, load_data;
   hsize_t hsize;
   logic htrans, hwrite, load_valid, illegal_instruction;
   reg_idx_t load_rd;

   logic [31:0] lfsr_state = 32'h77e753e8;
   exp_t acc_q[$];
   exp_t dp_q[$];
   logic dp_pending, exp_illegal, cur_illegal;
   logic prev_hready, prev_htrans;
   word_t prev_haddr;

   `include "lsu_ref.svh"

   lsu_top UUT (.*);

   function automatic logic [31:0] rand_bits(input int n);
      logic [31:0] r;
      r = '0;
      for (int i = 0; i < n; i++) begin
         r = {r[30:0], lfsr_state[0]};
         lfsr_state = lfsr_step(lfsr_state);
      end
      return r;
   endfunction

   // ====================
   // Compare tasks
   // ====================
   task automatic report_value(input string name, input word_t e, input word_t a);
      $display("Error %s expected %h actual %h", name, e, a);
      $display("Simulation finished: FAIL");
      $fatal(1, "value mismatch");
   endtask

   task automatic check_word(input string name, input word_t e, input word_t a);
      if (e !== a) report_value(name, e, a);
   endtask

   task automatic check_size(input string name, input hsize_t e, input hsize_t a);
      if (e !== a) report_value(name, word_t'(e), word_t'(a));
   endtask

   task automatic check_rd(input string name, input reg_idx_t e, input reg_idx_t a);
      if (e !== a) report_value(name, word_t'(e), word_t'(a));
   endtask

   task automatic check_flag(input string name, input logic e, input logic a);
      if (e !== a) report_value(name, word_t'(e), word_t'(a));
   endtask

   initial begin
      clk = 1'b0;
      forever #5 clk = ~clk;
   end

   // Memory model follows the address phase into the data phase
   always @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         dp_pending <= 1'b0;
      end else if (hready) begin
         dp_pending <= htrans;
         hrdata     <= mem_scramble(haddr);
      end
   end

   // ====================
   // Comparing process
   // ====================
   always @(negedge clk) begin
      exp_t e;
      if (rst_n) begin
         check_flag("illegal pulse", exp_illegal, illegal_instruction);
         // Address phase is open exactly while an accepted op waits in the queue
         check_flag("htrans", acc_q.size() != 0, htrans);
         if (!prev_hready) begin
            check_word("haddr under wait", prev_haddr, haddr);
            check_flag("htrans under wait", prev_htrans, htrans);
         end
         if (dp_pending && hready) begin
            e = dp_q.pop_front();
            check_flag({e.name, " load_valid"}, e.is_load, load_valid);
            if (e.is_load) begin
               check_rd({e.name, " load_rd"}, e.rd, load_rd);
               check_word({e.name, " load_data"},
                          extract_load(mem_scramble(e.addr), e.width, e.addr[1:0]), load_data);
            end else begin
               check_word({e.name, " hwdata"}, e.wdata, hwdata);
            end
         end else begin
            check_flag("load_valid outside data phase end", 1'b0, load_valid);
         end
         if (htrans && hready) begin
            e = acc_q.pop_front();
            check_word({e.name, " haddr"}, e.addr, haddr);
            check_size({e.name, " hsize"}, e.size, hsize);
            check_flag({e.name, " hwrite"}, !e.is_load, hwrite);
            dp_q.push_back(e);
         end
         prev_hready = hready;
         prev_htrans = htrans;
         prev_haddr  = haddr;
      end
   end

   // One clock edge and whether hready was high at it
   task automatic step(output logic acc);
      @(posedge clk);
      acc = hready;
      exp_illegal <= hready & instr_valid & cur_illegal;
      hready <= (rand_bits(2) != 0);
   endtask

   // ====================
   // Stimulus
   // ====================
   initial begin
      access_t ld_widths[5] = '{acc_byte, acc_half, acc_word, acc_byte_u, acc_half_u};
      access_t st_widths[3] = '{acc_byte, acc_half, acc_word};
      exp_t e;
      logic acc;
      logic [2:0] kind;
      logic [11:0] imm;
      logic [6:0] opc;
      reg_idx_t rd, r1, r2;
      word_t v1, v2;
      rst_n = 1'b0;
      instr = '0;
      instr_valid = 1'b0;
      rs1_data = '0;
      rs2_data = '0;
      hrdata = '0;
      hready = 1'b1;
      exp_illegal = 1'b0;
      cur_illegal = 1'b0;
      prev_hready = 1'b1;
      repeat (4) @(posedge clk);
      rst_n <= 1'b1;
      for (int i = 0; i < num_ops; i++) begin
         kind = 3'(rand_bits(3));
         imm  = 12'(rand_bits(12));
         rd   = 5'(rand_bits(5));
         r1   = 5'(rand_bits(5));
         r2   = 5'(rand_bits(5));
         v1   = rand_bits(32);
         v2   = rand_bits(32);
         e.addr = expected_addr(v1, imm);
         e.rd = rd;
         cur_illegal = (kind == 0);
         if (kind == 0) begin
            // Flip bit 4 so the opcode is neither load nor store
            opc = (rand_bits(1) ? opcode_load : opcode_store) ^ 7'b0010000;
            instr <= {imm, r1, 3'(rand_bits(3)), rd, opc};
         end else if (kind <= 4) begin
            e.is_load = 1'b1;
            e.width = ld_widths[3'(rand_bits(8) % 5)];
            e.name = "load";
            instr <= {imm, r1, 3'(e.width), rd, opcode_load};
         end else begin
            e.is_load = 1'b0;
            e.width = st_widths[2'(rand_bits(8) % 3)];
            e.name = "store";
            e.wdata = steer_store(v2, e.width, e.addr[1:0]);
            instr <= {imm[11:5], r2, r1, 3'(e.width), imm[4:0], opcode_store};
         end
         e.size = expected_size(e.width);
         instr_valid <= 1'b1;
         rs1_data <= v1;
         rs2_data <= v2;
         do step(acc); while (!acc);
         if (!cur_illegal) acc_q.push_back(e);
      end
      instr_valid <= 1'b0;
      cur_illegal = 1'b0;
      while (acc_q.size() != 0 || dp_q.size() != 0) step(acc);
      repeat (3) step(acc);
      $display("Simulation finished: PASS");
      $finish;
   end

   // Watchdog of 20 cycles per operation
   initial begin
      #(num_ops * 20 * 10);
      $display("Timeout, operations did not complete in time");
      $display("Simulation finished: FAIL");
      $fatal(1, "timeout");
   end

endmodule

//--- files.f
+incdir+tests
source/lsu_pkg.sv
source/lsu_decode.sv
source/lsu_addr_phase.sv
source/lsu_data_phase.sv
source/lsu_top.sv
tests/lsu_tb.sv

//--- Makefile
# Verilator build and run for the load/store unit

LOG := sim.log

.PHONY: all run lint clean

all: run

obj_dir/Vlsu_tb: files.f
	verilator --binary --timing --assert -f files.f --top-module lsu_tb

run: obj_dir/Vlsu_tb
	-./obj_dir/Vlsu_tb | tee $(LOG)
	@if grep -q "Simulation finished: FAIL" $(LOG); then exit 1; fi
	@grep -q "Simulation finished: PASS" $(LOG)

lint:
	verilator --lint-only --timing -f files.f --top-module lsu_tb

clean:
	rm -rf obj_dir $(LOG)
